//--- spio_link_macros.svh
// link transmitter parameters
`ifndef SPIO_LINK_MACROS_SVH
`define SPIO_LINK_MACROS_SVH

// ----------------------------------------------------------
// packet format
// ----------------------------------------------------------
`define PKT_BITS 72           // long packet, header + key + payload

// data nibbles sent per packet, end-of-packet not counted
`define SHORT_NIBBLES 10      // header + key
`define LONG_NIBBLES 18       // header + key + payload

// ----------------------------------------------------------
// link timing
// ----------------------------------------------------------
// flops between the async ack wire and the clock domain
`define ACK_SYNC_STAGES 2

`endif

//--- spio_pkt_pkg.sv
// packet format types
package spio_pkt_pkg;

  // ----------------------------------------------------------
  // header byte
  // ----------------------------------------------------------
  typedef struct packed {
    logic [5:0] ctrl;          // packet type and routing control
    logic       pl_flag;       // bit 1, payload present (long packet)
    logic       parity;        // bit 0, odd parity over the packet
  } hdr_t;

  // ----------------------------------------------------------
  // whole packet
  // ----------------------------------------------------------
  // header sits in the low byte so it goes out first
  // short packets use only the low 40 bits
  typedef struct packed {
    logic [31:0] payload;      // long packets only
    logic [31:0] key;          // routing key
    hdr_t        hdr;          // bits 7:0
  } pkt_t;

endpackage

//--- spio_sym_pkg.sv
// link symbol coding
package spio_sym_pkg;

  // one level per link wire
  typedef logic [6:0] code_t;

  // ----------------------------------------------------------
  // 2-of-7 symbol table, indexed by nibble value
  // ----------------------------------------------------------
  // 0..11 take one of bits 6:4 with one of bits 3:0
  // 12..15 take two adjacent low bits
  localparam code_t SYM_TABLE [16] = '{
    7'b0010001,   // 0
    7'b0010010,   // 1
    7'b0010100,   // 2
    7'b0011000,   // 3
    7'b0100001,   // 4
    7'b0100010,   // 5
    7'b0100100,   // 6
    7'b0101000,   // 7
    7'b1000001,   // 8
    7'b1000010,   // 9
    7'b1000100,   // 10
    7'b1001000,   // 11
    7'b0000011,   // 12
    7'b0000110,   // 13
    7'b0001100,   // 14
    7'b0001001    // 15, wraps bit 3 to bit 0
  };

  // end of packet, never used by a nibble
  localparam code_t SYM_EOP = 7'b1100000;

  // ----------------------------------------------------------
  // NRZ encoding
  // ----------------------------------------------------------
  // a symbol is sent by flipping its two wires, so the new
  // wire state is the old one xor the symbol
  function automatic code_t nrz_encode(
    input code_t      prev,    // current wire levels
    input logic       eop,     // send end-of-packet instead
    input logic [3:0] nib      // data nibble
  );
    code_t sym;
    sym = eop ? SYM_EOP : SYM_TABLE[nib];
    return prev ^ sym;
  endfunction

endpackage

//--- spio_pkt_serializer.sv
// packet to 2-of-7 word serializer
`timescale 1ns/1ps
`include "spio_link_macros.svh"

module spio_pkt_serializer (
  input  logic                CLK_IN,
  input  logic                RESET_IN,

  // packet side
  input  spio_pkt_pkg::pkt_t  pkt_data,
  input  logic                pkt_vld,
  output logic                pkt_rdy,

  // word side, towards the link driver
  output spio_sym_pkg::code_t flt_data,  // NRZ wire levels
  output logic                flt_vld,
  input  logic                flt_rdy
);

  localparam int CNT_W = $clog2(`LONG_NIBBLES + 1);

  typedef enum logic [1:0] {
    ST_IDLE,   // no packet, or last eop still with the driver
    ST_TRAN,   // shifting nibbles out
    ST_PARK    // packet held until the driver frees up
  } state_t;

  state_t               state;
  logic [`PKT_BITS-1:0] pkt_buf;    // nibble 0 at the bottom
  logic                 long_pkt;   // latched header bit 1
  logic [CNT_W-1:0]     nib_cnt;    // words already handed over
  logic                 flt_busy;   // word waiting on the driver
  logic                 eop;        // next word is end-of-packet
  logic                 pkt_take;   // packet accepted this cycle

  assign flt_busy = flt_vld && !flt_rdy;
  assign pkt_take = (state == ST_IDLE) && pkt_vld && pkt_rdy;

  // all data nibbles gone once the count reaches the length
  assign eop = (!long_pkt && (nib_cnt == CNT_W'(`SHORT_NIBBLES)))
            || (nib_cnt == CNT_W'(`LONG_NIBBLES));

  // ----------------------------------------------------------
  // FSM
  // ----------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (pkt_take)
                   state <= flt_busy ? ST_PARK : ST_TRAN;
        ST_PARK: if (!flt_busy)
                   state <= ST_TRAN;  // first nibble goes now
        default: if (eop && !flt_busy)
                   state <= ST_IDLE;  // eop handed over
      endcase
    end
  end

  // ready drops after a transfer, back once eop is handed over
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      pkt_rdy <= 1'b1;
    end else begin
      case (state)
        ST_IDLE: pkt_rdy <= !pkt_take;
        ST_TRAN: pkt_rdy <= eop && !flt_busy;
        default: pkt_rdy <= 1'b0;
      endcase
    end
  end

  // ----------------------------------------------------------
  // packet buffer
  // ----------------------------------------------------------
  always_ff @(posedge CLK_IN) begin
    case (state)
      ST_IDLE: begin
        if (pkt_take && flt_busy)
          pkt_buf <= pkt_data;                           // park whole packet
        else if (pkt_take)
          pkt_buf <= {4'h0, pkt_data[`PKT_BITS-1:4]};    // nibble 0 sent now
      end
      default: if (!flt_busy)
                 pkt_buf <= {4'h0, pkt_buf[`PKT_BITS-1:4]};
    endcase
  end

  always_ff @(posedge CLK_IN) begin
    if (pkt_take)
      long_pkt <= pkt_data.hdr.pl_flag;
  end

  // counts from 1, the first word leaves with the state change
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      nib_cnt <= CNT_W'(1);
    end else if (state == ST_TRAN) begin
      if (!flt_busy)
        nib_cnt <= nib_cnt + 1'b1;
    end else begin
      nib_cnt <= CNT_W'(1);
    end
  end

  // ----------------------------------------------------------
  // word output
  // ----------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flt_data <= '0;                                    // wires start low
    end else begin
      case (state)
        ST_IDLE: if (pkt_take && !flt_busy)
                   flt_data <= spio_sym_pkg::nrz_encode(flt_data, 1'b0, pkt_data[3:0]);
        default: if (!flt_busy)                          // parked nibble 0 too
                   flt_data <= spio_sym_pkg::nrz_encode(flt_data, eop, pkt_buf[3:0]);
      endcase
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN)
      flt_vld <= 1'b0;
    else if (state == ST_IDLE)
      flt_vld <= pkt_take || flt_busy;  // new packet or eop not yet taken
    else
      flt_vld <= 1'b1;                  // always a next word mid-packet
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  a_flt_hold: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    flt_busy |=> $stable(flt_data));

  // consecutive words differ by one symbol
  a_flt_2of7: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    $changed(flt_data) |-> ($countones(flt_data ^ $past(flt_data)) == 2));

endmodule

//--- spio_flit_output.sv
// link wire driver with ack handshake
`timescale 1ns/1ps
`include "spio_link_macros.svh"

module spio_flit_output (
  input  logic                CLK_IN,
  input  logic                RESET_IN,

  // word side, from the serializer
  input  spio_sym_pkg::code_t flt_data,
  input  logic                flt_vld,
  output logic                flt_rdy,

  // link side
  output spio_sym_pkg::code_t sl_data_2of7,
  input  logic                sl_ack       // async to CLK_IN
);

  typedef enum logic {
    ST_IDLE,   // wires settled, nothing owed
    ST_WAIT    // word on the wires, ack outstanding
  } state_t;

  state_t                      state;
  logic [`ACK_SYNC_STAGES-1:0] ack_sync;   // sync chain, msb is safe
  logic                        ack_prev;   // last synced level
  logic                        acked;      // ack toggled

  // ----------------------------------------------------------
  // ack synchronizer and edge detect
  // ----------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      ack_sync <= '0;
      ack_prev <= 1'b0;
    end else begin
      ack_sync <= {ack_sync[`ACK_SYNC_STAGES-2:0], sl_ack};
      ack_prev <= ack_sync[`ACK_SYNC_STAGES-1];
    end
  end

  assign acked = ack_sync[`ACK_SYNC_STAGES-1] != ack_prev;  // either edge

  // ----------------------------------------------------------
  // handshake FSM
  // ----------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state        <= ST_IDLE;
      flt_rdy      <= 1'b1;
      sl_data_2of7 <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (flt_vld) begin
            sl_data_2of7 <= flt_data;  // straight onto the wires
            flt_rdy      <= 1'b0;
            state        <= ST_WAIT;
          end
        end
        default: begin
          flt_rdy <= acked;            // one cycle high per ack
          if (acked && flt_vld)
            sl_data_2of7 <= flt_data;  // next word, no idle gap
          else if (acked)
            state <= ST_IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  // wires never move while the receiver still owes an ack
  a_wire_ack: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    $changed(sl_data_2of7) |-> $past((state == ST_IDLE) || acked));

endmodule

//--- spio_link_sender.sv
// link transmitter top level
`timescale 1ns/1ps

module spio_link_sender (
  input  logic                CLK_IN,
  input  logic                RESET_IN,

  // synchronous packet port
  input  spio_pkt_pkg::pkt_t  pkt_data,
  input  logic                pkt_vld,
  output logic                pkt_rdy,

  // 2-of-7 link port
  output spio_sym_pkg::code_t sl_data_2of7,
  input  logic                sl_ack
);

  // ----------------------------------------------------------
  // serializer to driver words
  // ----------------------------------------------------------
  spio_sym_pkg::code_t flt_data;   // NRZ accumulated
  logic                flt_vld;
  logic                flt_rdy;

  spio_pkt_serializer u_ser (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .pkt_data (pkt_data),
    .pkt_vld  (pkt_vld),
    .pkt_rdy  (pkt_rdy),
    .flt_data (flt_data),
    .flt_vld  (flt_vld),
    .flt_rdy  (flt_rdy)
  );

  spio_flit_output u_out (
    .CLK_IN       (CLK_IN),
    .RESET_IN     (RESET_IN),
    .flt_data     (flt_data),
    .flt_vld      (flt_vld),
    .flt_rdy      (flt_rdy),
    .sl_data_2of7 (sl_data_2of7),
    .sl_ack       (sl_ack)         // raw, synced inside
  );

endmodule

//--- tb_spio_link_sender.sv
// link transmitter testbench
`timescale 1ns/1ps
`include "spio_link_macros.svh"

module tb_spio_link_sender;

  localparam int NUM_PKTS   = 60;
  localparam int CLK_PERIOD = 20;
  // 16 cycles per word for 19 words per long packet plus slack
  localparam int TIMEOUT_NS = NUM_PKTS * 19 * 16 * CLK_PERIOD + 200 * CLK_PERIOD;

  logic                CLK_IN;
  logic                RESET_IN;
  spio_pkt_pkg::pkt_t  pkt_data;
  logic                pkt_vld;
  logic                pkt_rdy;
  spio_sym_pkg::code_t sl_data_2of7;
  logic                sl_ack;

  integer             seed;
  int                 err_mismatch;
  int                 err_other;
  int                 tx_count;
  int                 rx_count;
  spio_pkt_pkg::pkt_t sent_q [$];        // accepted but not yet seen on the link

  // receiver model
  spio_sym_pkg::code_t  rx_prev;         // wire levels after the last word
  logic [`PKT_BITS-1:0] rx_buf;          // nibbles rebuilt lsb first
  int                   rx_nibs;
  logic                 ack_owed;        // word seen and ack not yet given
  int                   ack_wait;        // cycles left before the ack
  logic                 ack_req;         // level the ack wire should take

  spio_link_sender UUT (
    .CLK_IN       (CLK_IN),
    .RESET_IN     (RESET_IN),
    .pkt_data     (pkt_data),
    .pkt_vld      (pkt_vld),
    .pkt_rdy      (pkt_rdy),
    .sl_data_2of7 (sl_data_2of7),
    .sl_ack       (sl_ack)
  );

  always #10 CLK_IN = ~CLK_IN;           // 20 ns period

  // ----------------------------------------------------------
  // checking helpers
  // ----------------------------------------------------------
  task automatic check_value(input string name, input logic [`PKT_BITS-1:0] got,
                             input logic [`PKT_BITS-1:0] exp);
    if (got !== exp) begin
      err_mismatch++;
      $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    err_other++;
    $display("Error at %0t ns: %s", $time, what);
  endtask

  task automatic print_summary();
    $display("errors: %0d mismatches, %0d other; packets sent %0d, received %0d",
             err_mismatch, err_other, tx_count, rx_count);
  endtask

  // nibble value or 16 for end-of-packet or -1 if no symbol matches
  function automatic int decode_symbol(input spio_sym_pkg::code_t sym);
    int val;
    val = -1;
    if (sym == spio_sym_pkg::SYM_EOP)
      val = 16;
    for (int i = 0; i < 16; i++)
      if (sym == spio_sym_pkg::SYM_TABLE[i])
        val = i;
    return val;
  endfunction

  // compare the rebuilt packet with the oldest one sent
  task automatic finish_packet();
    spio_pkt_pkg::pkt_t   exp;
    logic [`PKT_BITS-1:0] mask;
    int                   exp_nibs;
    if (sent_q.size() == 0) begin
      report_failure("end-of-packet seen with no packet outstanding");
    end else begin
      exp      = sent_q.pop_front();
      exp_nibs = exp.hdr.pl_flag ? `LONG_NIBBLES : `SHORT_NIBBLES;  // header bit 1
      mask     = '1;
      mask     = mask >> (`PKT_BITS - 4 * exp_nibs);               // short keeps 40 bits
      check_value("nibble count", rx_nibs, exp_nibs);
      check_value("packet", rx_buf & mask, exp & mask);
    end
    rx_count++;                                        // every end-of-packet counts
    rx_buf  = '0;
    rx_nibs = 0;
  endtask

  // ----------------------------------------------------------
  // receiver model sampling the wires mid cycle
  // ----------------------------------------------------------
  always @(negedge CLK_IN) begin : receiver
    spio_sym_pkg::code_t sym;
    int                  nib;
    if (RESET_IN) begin
      rx_prev  = '0;
      rx_buf   = '0;
      rx_nibs  = 0;
      ack_owed = 1'b0;
      ack_wait = 0;
    end else if (sl_data_2of7 !== rx_prev) begin
      sym = sl_data_2of7 ^ rx_prev;                   // NRZ gives the toggled wires
      if (ack_owed)
        report_failure("link wires changed before the acknowledge was given");
      check_value("toggled wires", $countones(sym), 2);
      nib = decode_symbol(sym);
      if (nib < 0)
        report_failure($sformatf("unknown symbol %b on the link", sym));
      else if (nib == 16)
        finish_packet();
      else if (rx_nibs >= `LONG_NIBBLES)
        report_failure("too many nibbles without an end-of-packet");
      else begin
        rx_buf[rx_nibs*4 +: 4] = 4'(nib);
        rx_nibs++;
      end
      rx_prev  = sl_data_2of7;
      ack_owed = 1'b1;
      ack_wait = 1 + ($unsigned($random(seed)) % 12);  // 1 to 12 cycles
    end else if (ack_owed) begin
      ack_wait--;
      if (ack_wait == 0) begin
        ack_req  = ~ack_req;                           // either edge acks
        ack_owed = 1'b0;
      end
    end
  end

  always @(posedge CLK_IN)
    sl_ack <= ack_req;

  // ----------------------------------------------------------
  // packet source
  // ----------------------------------------------------------
  // pkt_rdy read at the edge is the value from the cycle before it
  task automatic send_packet(input spio_pkt_pkg::pkt_t pkt);
    pkt_data <= pkt;
    pkt_vld  <= 1'b1;
    @(posedge CLK_IN);
    while (!pkt_rdy)
      @(posedge CLK_IN);
    sent_q.push_back(pkt);                             // taken on this edge
    tx_count++;
    pkt_vld  <= 1'b0;
    pkt_data <= '0;
    @(posedge CLK_IN);
    check_value("pkt_rdy after transfer", pkt_rdy, 1'b0);
  endtask

  initial begin : main
    spio_pkt_pkg::pkt_t pkt;
    int                 gap;
    seed         = 32483;
    err_mismatch = 0;
    err_other    = 0;
    tx_count     = 0;
    rx_count     = 0;
    ack_req      = 1'b0;
    CLK_IN       = 1'b0;
    RESET_IN     = 1'b1;
    pkt_data     = '0;
    pkt_vld      = 1'b0;
    sl_ack       = 1'b0;
    repeat (4) @(posedge CLK_IN);
    RESET_IN <= 1'b0;
    @(negedge CLK_IN);
    check_value("pkt_rdy", pkt_rdy, 1'b1);
    check_value("sl_data_2of7", sl_data_2of7, '0);
    for (int n = 0; n < NUM_PKTS; n++) begin
      gap = $unsigned($random(seed)) % 4;
      @(posedge CLK_IN);
      repeat (gap) @(posedge CLK_IN);
      pkt.payload     = $random(seed);
      pkt.key         = $random(seed);
      pkt.hdr         = 8'($random(seed));
      pkt.hdr.pl_flag = 1'($random(seed));             // long or short
      send_packet(pkt);
    end
    wait (rx_count == NUM_PKTS);
    repeat (20) @(posedge CLK_IN);                     // catch stray words
    check_value("packets received", rx_count, tx_count);
    check_value("nibbles after last packet", rx_nibs, 0);
    if (sent_q.size() != 0)
      report_failure("packets still outstanding at the end");
    print_summary();
    if (err_mismatch + err_other == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // ----------------------------------------------------------
  // watchdog
  // ----------------------------------------------------------
  initial begin : watchdog
    #(TIMEOUT_NS);
    report_failure($sformatf("timeout, %0d of %0d packets received", rx_count, NUM_PKTS));
    print_summary();
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- files.f
+incdir+.
spio_pkt_pkg.sv
spio_sym_pkg.sv
spio_pkt_serializer.sv
spio_flit_output.sv
spio_link_sender.sv
tb_spio_link_sender.sv

//--- Bender.yml
package:
  name: spio_link_sender

export_include_dirs:
  - .

sources:
  # packages first, then the design bottom up
  - include_dirs:
      - .
    files:
      - spio_pkt_pkg.sv
      - spio_sym_pkg.sv
      - spio_pkt_serializer.sv
      - spio_flit_output.sv
      - spio_link_sender.sv

  # testbench, simulation only
  - target: test
    include_dirs:
      - .
    files:
      - tb_spio_link_sender.sv
